/* hci_pkg.sv */
// ==============================
// shared widths, apb register map and mux select codes.
// tcdm addresses are word addresses and wrap inside one bank.
// apb offsets are byte offsets and must be word aligned.
// ==============================
`default_nettype none

package hci_pkg;

  // ==============================
  // tcdm geometry.
  // ==============================
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned BE_W      = DATA_W / 8;
  localparam int unsigned ADDR_W    = 10;
  localparam int unsigned MEM_WORDS = 1 << ADDR_W;
  // one more bit than the address, so a run can span the whole bank.
  localparam int unsigned LEN_W     = ADDR_W + 1;

  // ==============================
  // apb register map.
  // ==============================
  localparam int unsigned APB_ADDR_W = 8;

  localparam logic [APB_ADDR_W-1:0] REG_CTRL    = 8'h00;
  localparam logic [APB_ADDR_W-1:0] REG_BASE    = 8'h04;
  localparam logic [APB_ADDR_W-1:0] REG_LEN     = 8'h08;
  localparam logic [APB_ADDR_W-1:0] REG_PATTERN = 8'h0C;
  localparam logic [APB_ADDR_W-1:0] REG_STATUS  = 8'h10;
  localparam logic [APB_ADDR_W-1:0] REG_SUM     = 8'h14;

  // select codes of the static mux.
  localparam logic SEL_FILL = 1'b0;
  localparam logic SEL_SUM  = 1'b1;

endpackage

`default_nettype wire

/* hci_apb_ctrl.sv */
// ==============================
// apb register file and fill/sum run sequencer.
// no wait states. config writes are dropped while a run is busy.
// a start while busy is ignored. done is sticky until the next start.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module hci_apb_ctrl (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           apb_psel_i,
  input  logic                           apb_penable_i,
  input  logic                           apb_pwrite_i,
  input  logic [hci_pkg::APB_ADDR_W-1:0] apb_paddr_i,
  input  logic [hci_pkg::DATA_W-1:0]     apb_pwdata_i,
  output logic [hci_pkg::DATA_W-1:0]     apb_prdata_o,
  output logic                           apb_pready_o,
  output logic                           apb_pslverr_o,
  output logic                           fill_start_o,
  output logic                           sum_start_o,
  output logic [hci_pkg::ADDR_W-1:0]     base_o,
  output logic [hci_pkg::LEN_W-1:0]      len_o,
  output logic [hci_pkg::DATA_W-1:0]     pattern_o,
  output logic                           sel_o,
  output logic                           done_o,
  input  logic                           fill_done_i,
  input  logic                           sum_done_i,
  input  logic [hci_pkg::DATA_W-1:0]     sum_i
);
  import hci_pkg::*;

  typedef enum logic [1:0] {PH_IDLE, PH_FILL, PH_SUM} phase_e;

  phase_e            phase_q;
  logic              busy;
  logic              done_q;
  logic [DATA_W-1:0] sum_q;
  logic              access;
  logic              addr_ok;
  logic              wr_en;
  logic              start_req;

  // ==============================
  // apb decode.
  // ==============================
  assign access  = apb_psel_i & apb_penable_i;
  // word aligned and inside the six-register window.
  assign addr_ok = (apb_paddr_i[1:0] == 2'b00) && (apb_paddr_i <= REG_SUM);
  assign wr_en   = access & apb_pwrite_i & addr_ok;

  assign apb_pready_o  = access;
  assign apb_pslverr_o = access & ~addr_ok;

  assign busy      = (phase_q != PH_IDLE);
  assign start_req = wr_en && (apb_paddr_i == REG_CTRL) && apb_pwdata_i[0] && !busy;

  // read mux, ctrl and unmapped offsets read as zero.
  always_comb begin
    case (apb_paddr_i)
      REG_BASE:    apb_prdata_o = DATA_W'(base_o);
      REG_LEN:     apb_prdata_o = DATA_W'(len_o);
      REG_PATTERN: apb_prdata_o = pattern_o;
      REG_STATUS:  apb_prdata_o = {{(DATA_W-2){1'b0}}, done_q, busy};
      REG_SUM:     apb_prdata_o = sum_q;
      default:     apb_prdata_o = '0;
    endcase
  end

  // configuration registers, frozen during a run.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      base_o    <= '0;
      len_o     <= '0;
      pattern_o <= '0;
    end else if (wr_en && !busy) begin
      case (apb_paddr_i)
        REG_BASE:    base_o    <= apb_pwdata_i[ADDR_W-1:0];
        REG_LEN:     len_o     <= apb_pwdata_i[LEN_W-1:0];
        REG_PATTERN: pattern_o <= apb_pwdata_i;
        default:     ;
      endcase
    end
  end

  // ==============================
  // run sequencer.
  // ==============================
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q      <= PH_IDLE;
      done_q       <= 1'b0;
      sum_q        <= '0;
      sel_o        <= SEL_FILL;
      fill_start_o <= 1'b0;
      sum_start_o  <= 1'b0;
      done_o       <= 1'b0;
    end else begin
      // pulses default low.
      fill_start_o <= 1'b0;
      sum_start_o  <= 1'b0;
      done_o       <= 1'b0;
      case (phase_q)
        PH_IDLE: begin
          if (start_req) begin
            phase_q      <= PH_FILL;
            done_q       <= 1'b0;
            sel_o        <= SEL_FILL;
            fill_start_o <= 1'b1;
          end
        end
        PH_FILL: begin
          // fill has no traffic in flight once it reports done.
          if (fill_done_i) begin
            phase_q     <= PH_SUM;
            sel_o       <= SEL_SUM;
            sum_start_o <= 1'b1;
          end
        end
        PH_SUM: begin
          if (sum_done_i) begin
            phase_q <= PH_IDLE;
            done_q  <= 1'b1;
            sum_q   <= sum_i;
            sel_o   <= SEL_FILL;
            done_o  <= 1'b1;
          end
        end
        default: phase_q <= PH_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hci_fill_streamer.sv */
// ==============================
// tcdm write master, word base+i gets pattern+i.
// base, len and pattern must stay stable from start to done.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module hci_fill_streamer (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        start_i,
  input  logic [hci_pkg::ADDR_W-1:0]  base_i,
  input  logic [hci_pkg::LEN_W-1:0]   len_i,
  input  logic [hci_pkg::DATA_W-1:0]  pattern_i,
  output logic                        done_o,
  output logic                        tcdm_req_o,
  input  logic                        tcdm_gnt_i,
  output logic [hci_pkg::ADDR_W-1:0]  tcdm_add_o,
  output logic                        tcdm_wen_o,
  output logic [hci_pkg::DATA_W-1:0]  tcdm_data_o,
  output logic [hci_pkg::BE_W-1:0]    tcdm_be_o
);
  import hci_pkg::*;

  logic             active_q;
  logic [LEN_W-1:0] idx_q;
  logic             last;

  assign last = (idx_q == len_i);

  // request held until granted, fields follow the index.
  assign tcdm_req_o  = active_q & ~last;
  // address wraps at the bank end.
  assign tcdm_add_o  = base_i + idx_q[ADDR_W-1:0];
  assign tcdm_wen_o  = 1'b0;
  assign tcdm_data_o = pattern_i + DATA_W'(idx_q);
  assign tcdm_be_o   = '1;

  // high for the one cycle after the last grant.
  assign done_o = active_q & last;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q <= 1'b0;
      idx_q    <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      idx_q    <= '0;
    end else if (done_o) begin
      active_q <= 1'b0;
    end else if (tcdm_req_o && tcdm_gnt_i) begin
      idx_q <= idx_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hci_sum_streamer.sv */
// ==============================
// pipelined tcdm read master with a wrapping 32-bit sum.
// reads issue on every grant, so several can be in flight.
// sum_o is final when done_o pulses.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module hci_sum_streamer (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        start_i,
  input  logic [hci_pkg::ADDR_W-1:0]  base_i,
  input  logic [hci_pkg::LEN_W-1:0]   len_i,
  output logic                        done_o,
  output logic [hci_pkg::DATA_W-1:0]  sum_o,
  output logic                        tcdm_req_o,
  input  logic                        tcdm_gnt_i,
  output logic [hci_pkg::ADDR_W-1:0]  tcdm_add_o,
  output logic                        tcdm_wen_o,
  output logic [hci_pkg::DATA_W-1:0]  tcdm_data_o,
  output logic [hci_pkg::BE_W-1:0]    tcdm_be_o,
  input  logic [hci_pkg::DATA_W-1:0]  tcdm_r_data_i,
  input  logic                        tcdm_r_valid_i
);
  import hci_pkg::*;

  logic              active_q;
  logic [LEN_W-1:0]  iss_q;
  logic [LEN_W-1:0]  rsp_q;
  logic [DATA_W-1:0] acc_q;
  logic              rsp_en;

  // issue side, one read per granted cycle.
  assign tcdm_req_o  = active_q & (iss_q != len_i);
  assign tcdm_add_o  = base_i + iss_q[ADDR_W-1:0];
  assign tcdm_wen_o  = 1'b1;
  assign tcdm_data_o = '0;
  assign tcdm_be_o   = '1;

  // response side, counts returned words.
  assign rsp_en = active_q & tcdm_r_valid_i;
  assign done_o = active_q & (rsp_q == len_i);
  assign sum_o  = acc_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q <= 1'b0;
      iss_q    <= '0;
      rsp_q    <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      iss_q    <= '0;
      rsp_q    <= '0;
    end else if (done_o) begin
      active_q <= 1'b0;
    end else begin
      if (tcdm_req_o && tcdm_gnt_i) begin
        iss_q <= iss_q + 1'b1;
      end
      if (rsp_en) begin
        rsp_q <= rsp_q + 1'b1;
      end
    end
  end

  // accumulator, cleared by start.
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      acc_q <= '0;
    end else if (rsp_en) begin
      acc_q <= acc_q + tcdm_r_data_i;
    end
  end

endmodule

`default_nettype wire

/* hci_core_mux_static.sv */
// ==============================
// static two-way tcdm mux with no arbitration.
// the two inputs must never be active at the same time.
// clock and reset only match the dynamic mux's ports.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module hci_core_mux_static (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       sel_i,
  input  logic                       in0_tcdm_req_i,
  output logic                       in0_tcdm_gnt_o,
  input  logic [hci_pkg::ADDR_W-1:0] in0_tcdm_add_i,
  input  logic                       in0_tcdm_wen_i,
  input  logic [hci_pkg::DATA_W-1:0] in0_tcdm_data_i,
  input  logic [hci_pkg::BE_W-1:0]   in0_tcdm_be_i,
  output logic [hci_pkg::DATA_W-1:0] in0_tcdm_r_data_o,
  output logic                       in0_tcdm_r_valid_o,
  input  logic                       in1_tcdm_req_i,
  output logic                       in1_tcdm_gnt_o,
  input  logic [hci_pkg::ADDR_W-1:0] in1_tcdm_add_i,
  input  logic                       in1_tcdm_wen_i,
  input  logic [hci_pkg::DATA_W-1:0] in1_tcdm_data_i,
  input  logic [hci_pkg::BE_W-1:0]   in1_tcdm_be_i,
  output logic [hci_pkg::DATA_W-1:0] in1_tcdm_r_data_o,
  output logic                       in1_tcdm_r_valid_o,
  output logic                       out_tcdm_req_o,
  input  logic                       out_tcdm_gnt_i,
  output logic [hci_pkg::ADDR_W-1:0] out_tcdm_add_o,
  output logic                       out_tcdm_wen_o,
  output logic [hci_pkg::DATA_W-1:0] out_tcdm_data_o,
  output logic [hci_pkg::BE_W-1:0]   out_tcdm_be_o,
  input  logic [hci_pkg::DATA_W-1:0] out_tcdm_r_data_i,
  input  logic                       out_tcdm_r_valid_i
);
  import hci_pkg::*;

  logic use1;

  assign use1 = (sel_i == SEL_SUM);

  // request fields come from the selected port.
  assign out_tcdm_req_o  = use1 ? in1_tcdm_req_i  : in0_tcdm_req_i;
  assign out_tcdm_add_o  = use1 ? in1_tcdm_add_i  : in0_tcdm_add_i;
  assign out_tcdm_wen_o  = use1 ? in1_tcdm_wen_i  : in0_tcdm_wen_i;
  assign out_tcdm_data_o = use1 ? in1_tcdm_data_i : in0_tcdm_data_i;
  assign out_tcdm_be_o   = use1 ? in1_tcdm_be_i   : in0_tcdm_be_i;

  // handshakes go back to the selected port only.
  assign in0_tcdm_gnt_o     = ~use1 & out_tcdm_gnt_i;
  assign in1_tcdm_gnt_o     =  use1 & out_tcdm_gnt_i;
  assign in0_tcdm_r_valid_o = ~use1 & out_tcdm_r_valid_i;
  assign in1_tcdm_r_valid_o =  use1 & out_tcdm_r_valid_i;

  // read data is broadcast, r_valid qualifies it.
  assign in0_tcdm_r_data_o = out_tcdm_r_data_i;
  assign in1_tcdm_r_data_o = out_tcdm_r_data_i;

endmodule

`default_nettype wire

/* hci_tcdm_bank.sv */
// ==============================
// single-port tcdm bank, always grants.
// read data is registered, r_valid one cycle after the read.
// memory contents are undefined until written.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module hci_tcdm_bank (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       tcdm_req_i,
  output logic                       tcdm_gnt_o,
  input  logic [hci_pkg::ADDR_W-1:0] tcdm_add_i,
  input  logic                       tcdm_wen_i,
  input  logic [hci_pkg::DATA_W-1:0] tcdm_data_i,
  input  logic [hci_pkg::BE_W-1:0]   tcdm_be_i,
  output logic [hci_pkg::DATA_W-1:0] tcdm_r_data_o,
  output logic                       tcdm_r_valid_o
);
  import hci_pkg::*;

  logic [DATA_W-1:0] mem_q [MEM_WORDS];

  // no conflicts on a single owner, so every request is granted.
  assign tcdm_gnt_o = tcdm_req_i;

  // byte-enabled write, registered read.
  always_ff @(posedge clk_i) begin
    if (tcdm_req_i) begin
      if (!tcdm_wen_i) begin
        for (int b = 0; b < BE_W; b++) begin
          if (tcdm_be_i[b]) begin
            mem_q[tcdm_add_i][8*b +: 8] <= tcdm_data_i[8*b +: 8];
          end
        end
      end else begin
        tcdm_r_data_o <= mem_q[tcdm_add_i];
      end
    end
  end

  // writes return no response.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tcdm_r_valid_o <= 1'b0;
    end else begin
      tcdm_r_valid_o <= tcdm_req_i & tcdm_wen_i;
    end
  end

endmodule

`default_nettype wire

/* hci_fill_sum_top.sv */
// ==============================
// fill/sum subsystem top, apb in and one done pulse out.
// both streamers share one bank through the static mux.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module hci_fill_sum_top (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           apb_psel_i,
  input  logic                           apb_penable_i,
  input  logic                           apb_pwrite_i,
  input  logic [hci_pkg::APB_ADDR_W-1:0] apb_paddr_i,
  input  logic [hci_pkg::DATA_W-1:0]     apb_pwdata_i,
  output logic [hci_pkg::DATA_W-1:0]     apb_prdata_o,
  output logic                           apb_pready_o,
  output logic                           apb_pslverr_o,
  output logic                           done_o
);
  import hci_pkg::*;

  // ==============================
  // control nets.
  // ==============================
  logic              fill_start;
  logic              sum_start;
  logic              fill_done;
  logic              sum_done;
  logic              sel;
  logic [ADDR_W-1:0] base;
  logic [LEN_W-1:0]  len;
  logic [DATA_W-1:0] pattern;
  logic [DATA_W-1:0] sum;

  // fill master port.
  logic              fill_req;
  logic              fill_gnt;
  logic [ADDR_W-1:0] fill_add;
  logic              fill_wen;
  logic [DATA_W-1:0] fill_data;
  logic [BE_W-1:0]   fill_be;

  // sum master port.
  logic              sum_req;
  logic              sum_gnt;
  logic [ADDR_W-1:0] sum_add;
  logic              sum_wen;
  logic [DATA_W-1:0] sum_data;
  logic [BE_W-1:0]   sum_be;
  logic [DATA_W-1:0] sum_r_data;
  logic              sum_r_valid;

  // bank port.
  logic              mem_req;
  logic              mem_gnt;
  logic [ADDR_W-1:0] mem_add;
  logic              mem_wen;
  logic [DATA_W-1:0] mem_data;
  logic [BE_W-1:0]   mem_be;
  logic [DATA_W-1:0] mem_r_data;
  logic              mem_r_valid;

  // ==============================
  // instances.
  // ==============================
  hci_apb_ctrl u_ctrl (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .apb_psel_i    (apb_psel_i),
    .apb_penable_i (apb_penable_i),
    .apb_pwrite_i  (apb_pwrite_i),
    .apb_paddr_i   (apb_paddr_i),
    .apb_pwdata_i  (apb_pwdata_i),
    .apb_prdata_o  (apb_prdata_o),
    .apb_pready_o  (apb_pready_o),
    .apb_pslverr_o (apb_pslverr_o),
    .fill_start_o  (fill_start),
    .sum_start_o   (sum_start),
    .base_o        (base),
    .len_o         (len),
    .pattern_o     (pattern),
    .sel_o         (sel),
    .done_o        (done_o),
    .fill_done_i   (fill_done),
    .sum_done_i    (sum_done),
    .sum_i         (sum)
  );

  hci_fill_streamer u_fill (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .start_i     (fill_start),
    .base_i      (base),
    .len_i       (len),
    .pattern_i   (pattern),
    .done_o      (fill_done),
    .tcdm_req_o  (fill_req),
    .tcdm_gnt_i  (fill_gnt),
    .tcdm_add_o  (fill_add),
    .tcdm_wen_o  (fill_wen),
    .tcdm_data_o (fill_data),
    .tcdm_be_o   (fill_be)
  );

  hci_sum_streamer u_sum (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .start_i        (sum_start),
    .base_i         (base),
    .len_i          (len),
    .done_o         (sum_done),
    .sum_o          (sum),
    .tcdm_req_o     (sum_req),
    .tcdm_gnt_i     (sum_gnt),
    .tcdm_add_o     (sum_add),
    .tcdm_wen_o     (sum_wen),
    .tcdm_data_o    (sum_data),
    .tcdm_be_o      (sum_be),
    .tcdm_r_data_i  (sum_r_data),
    .tcdm_r_valid_i (sum_r_valid)
  );

  // the fill master never reads, so its response outputs stay open.
  hci_core_mux_static u_mux (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .sel_i              (sel),
    .in0_tcdm_req_i     (fill_req),
    .in0_tcdm_gnt_o     (fill_gnt),
    .in0_tcdm_add_i     (fill_add),
    .in0_tcdm_wen_i     (fill_wen),
    .in0_tcdm_data_i    (fill_data),
    .in0_tcdm_be_i      (fill_be),
    .in0_tcdm_r_data_o  (),
    .in0_tcdm_r_valid_o (),
    .in1_tcdm_req_i     (sum_req),
    .in1_tcdm_gnt_o     (sum_gnt),
    .in1_tcdm_add_i     (sum_add),
    .in1_tcdm_wen_i     (sum_wen),
    .in1_tcdm_data_i    (sum_data),
    .in1_tcdm_be_i      (sum_be),
    .in1_tcdm_r_data_o  (sum_r_data),
    .in1_tcdm_r_valid_o (sum_r_valid),
    .out_tcdm_req_o     (mem_req),
    .out_tcdm_gnt_i     (mem_gnt),
    .out_tcdm_add_o     (mem_add),
    .out_tcdm_wen_o     (mem_wen),
    .out_tcdm_data_o    (mem_data),
    .out_tcdm_be_o      (mem_be),
    .out_tcdm_r_data_i  (mem_r_data),
    .out_tcdm_r_valid_i (mem_r_valid)
  );

  hci_tcdm_bank u_bank (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .tcdm_req_i     (mem_req),
    .tcdm_gnt_o     (mem_gnt),
    .tcdm_add_i     (mem_add),
    .tcdm_wen_i     (mem_wen),
    .tcdm_data_i    (mem_data),
    .tcdm_be_i      (mem_be),
    .tcdm_r_data_o  (mem_r_data),
    .tcdm_r_valid_o (mem_r_valid)
  );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// ==============================
// testbench clock and reset, 40 ns period.
// reset is held low for 5 cycles and released on a falling edge.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);
  localparam int unsigned HALF_NS    = 20;
  localparam int unsigned RST_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_NS) clk_o = ~clk_o;
    end
  end

  // release away from the rising edge.
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* tb_hci_fill_sum.sv */
// ==============================
// testbench for the fill/sum subsystem, driven over apb.
// expected sums come from a reference model of the fill pattern.
// a global cycle limit ends the run if done never arrives.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_hci_fill_sum;
  import hci_pkg::*;

  // 40 runs of a full bank fill and read back, plus slack.
  localparam int unsigned TIMEOUT_CYCLES = 40 * (2 * MEM_WORDS + 50);
  localparam int unsigned MAX_CHECKS     = 512;

  logic                  clk;
  logic                  arst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [DATA_W-1:0]     pwdata;
  logic [DATA_W-1:0]     prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  done;

  // stimulus records observed and expected pairs here for the compare process.
  logic [31:0] got_mem [MAX_CHECKS];
  logic [31:0] exp_mem [MAX_CHECKS];
  string       what_mem [MAX_CHECKS];
  int          n_pushed = 0;
  int          n_checked = 0;
  int          errors = 0;
  int          done_count = 0;
  int          done_target = 0;
  int unsigned cycle_cnt = 0;
  logic [31:0] exp_run_sum;
  logic [31:0] rd;
  logic        err;

  tb_clk_gen u_clk (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  hci_fill_sum_top dut0 (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .apb_psel_i    (psel),
    .apb_penable_i (penable),
    .apb_pwrite_i  (pwrite),
    .apb_paddr_i   (paddr),
    .apb_pwdata_i  (pwdata),
    .apb_prdata_o  (prdata),
    .apb_pready_o  (pready),
    .apb_pslverr_o (pslverr),
    .done_o        (done)
  );

  // ==============================
  // reference model and helpers.
  // ==============================
  // word i holds pattern+i, so the sum is independent of base.
  function automatic logic [31:0] ref_sum(input logic [31:0] pattern, input logic [31:0] len);
    logic [31:0] acc;
    acc = 32'h0;
    for (int unsigned i = 0; i < len; i++) begin
      acc = acc + pattern + i;
    end
    return acc;
  endfunction

  task automatic expect_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    got_mem[n_pushed]  = got;
    exp_mem[n_pushed]  = exp;
    what_mem[n_pushed] = what;
    n_pushed++;
  endtask

  // one setup phase and one access phase with no wait states.
  task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  // read data is sampled mid access phase.
  task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
                          output logic slverr);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data   = prdata;
    slverr = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic start_run(input logic [31:0] base, input logic [31:0] len,
                           input logic [31:0] pattern);
    apb_write(REG_BASE, base);
    apb_write(REG_LEN, len);
    apb_write(REG_PATTERN, pattern);
    exp_run_sum = ref_sum(pattern, len);
    done_target = done_count + 1;
    apb_write(REG_CTRL, 32'h1);
  endtask

  task automatic finish_run(input string what);
    logic [31:0] data;
    logic        slverr;
    while (done_count < done_target) begin
      @(negedge clk);
    end
    apb_read(REG_SUM, data, slverr);
    expect_value(data, exp_run_sum, {what, " sum"});
    apb_read(REG_STATUS, data, slverr);
    expect_value(data, 32'h2, {what, " status"});
  endtask

  // ==============================
  // monitors.
  // ==============================
  always @(negedge clk) begin
    if (done) begin
      done_count++;
    end
  end

  // every access phase completes at once.
  always @(negedge clk) begin
    if (psel && penable) begin
      assert (pready === 1'b1) else begin
        errors++;
        $display("** Error [%0t] pready low in an apb access phase", $time);
      end
    end
  end

  // compare process.
  always @(negedge clk) begin
    while (n_checked < n_pushed) begin
      assert (got_mem[n_checked] === exp_mem[n_checked]) else begin
        errors++;
        $display("** Error [%0t] %s: got 0x%h, expected 0x%h", $time,
                 what_mem[n_checked], got_mem[n_checked], exp_mem[n_checked]);
      end
      n_checked++;
    end
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("checks: %0d, errors: %0d", n_checked, errors);
    $display("Something failed");
    $finish;
  end

  // ==============================
  // stimulus.
  // ==============================
  initial begin
    void'($urandom(32'h5711eafa));
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    while (!arst_n) begin
      @(posedge clk);
    end

    // reset values, read back and decode errors.
    apb_read(REG_STATUS, rd, err);
    expect_value(rd, 32'h0, "status after reset");
    apb_read(REG_SUM, rd, err);
    expect_value(rd, 32'h0, "sum after reset");
    apb_write(REG_BASE, 32'h155);
    apb_write(REG_LEN, 32'h2ab);
    apb_write(REG_PATTERN, 32'hdeadbeef);
    apb_write(REG_SUM, 32'h1234);
    apb_read(REG_BASE, rd, err);
    expect_value(rd, 32'h155, "base readback");
    apb_read(REG_LEN, rd, err);
    expect_value(rd, 32'h2ab, "len readback");
    apb_read(REG_PATTERN, rd, err);
    expect_value(rd, 32'hdeadbeef, "pattern readback");
    expect_value(32'(err), 32'h0, "pslverr on mapped read");
    apb_read(REG_SUM, rd, err);
    expect_value(rd, 32'h0, "sum is read only");
    apb_read(8'h40, rd, err);
    expect_value(rd, 32'h0, "unmapped read data");
    expect_value(32'(err), 32'h1, "pslverr on unmapped read");
    apb_read(8'h06, rd, err);
    expect_value(32'(err), 32'h1, "pslverr on unaligned read");

    start_run(32'd100, 32'd64, 32'h10000000);
    finish_run("basic run");

    for (int r = 0; r < 30; r++) begin
      start_run($urandom % MEM_WORDS, $urandom % (MEM_WORDS + 1), $urandom);
      finish_run($sformatf("random run %0d", r));
    end

    start_run(32'd7, 32'd0, 32'h55aa55aa);
    finish_run("len 0 run");

    // second start lands mid run and must be dropped.
    start_run(32'd12, 32'd1024, 32'h0badcafe);
    repeat (20) @(posedge clk);
    apb_read(REG_STATUS, rd, err);
    expect_value(rd, 32'h1, "status while busy");
    apb_write(REG_CTRL, 32'h1);
    finish_run("busy start run");
    repeat (2200) @(posedge clk);
    expect_value(32'(done_count), 32'(done_target), "done pulses after ignored start");

    // short block overlaps stale words of the long one.
    start_run(32'd200, 32'd500, 32'h11111111);
    finish_run("long block");
    start_run(32'd300, 32'd50, 32'h22222222);
    finish_run("short overlapping block");

    while (n_checked < n_pushed) begin
      @(posedge clk);
    end
    $display("checks: %0d, errors: %0d", n_checked, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
hci_pkg.sv
hci_apb_ctrl.sv
hci_fill_streamer.sv
hci_sum_streamer.sv
hci_core_mux_static.sv
hci_tcdm_bank.sv
hci_fill_sum_top.sv
tb_clk_gen.sv
tb_hci_fill_sum.sv

/* run_sim.sh */
#!/bin/sh
# compile with verilator, run, and decide by the pass line in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module tb_hci_fill_sum -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "^Everything OK$" \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }
